// ==== Bender.yml ====
package:
  name: cpu_frontend

sources:
  - include_dirs:
      - design
    files:
      - design/frontend_pkg.sv
      - design/fetch_unit.sv
      - design/instr_buffer.sv
      - design/cpu_pipeline.sv
      - design/cpu_frontend.sv
      - target: test
        files:
          - tests/cpu_frontend_sva.sv
          - tests/tb_cpu_frontend.sv

// ==== design/cpu_frontend.sv ====
// CPU instruction front end
`include "frontend_defines.svh"

module cpu_frontend (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    stall,
	input  logic                    load_pc,
	input  logic [`ADDR_BITS-1:0]   target_pc,
	input  logic                    int_enable_set,
	input  logic                    interrupt,
	input  logic [3:0]              irq,
	output logic                    mem_req,
	output logic [`ADDR_BITS-1:0]   mem_addr,
	input  logic [`WORD_BITS-1:0]   mem_data,
	output frontend_pkg::retire_t   retire,
	output logic                    int_enabled
);

	import frontend_pkg::*;

	logic        push;
	fetch_word_t push_word;
	logic        credit_return;
	fetch_word_t head;
	logic        empty;
	logic        pop;

	// Producer
	fetch_unit u_fetch (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.load_pc       (load_pc),
		.target_pc     (target_pc),
		.credit_return (credit_return),
		.mem_req       (mem_req),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.push          (push),
		.push_word     (push_word)
	);

	instr_buffer u_buf (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.load_pc       (load_pc),
		.push          (push),
		.push_word     (push_word),
		.pop           (pop),
		.head          (head),
		.empty         (empty),
		.credit_return (credit_return)
	);

	// Consumer
	cpu_pipeline u_pipe (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.stall          (stall),
		.load_pc        (load_pc),
		.int_enable_set (int_enable_set),
		.interrupt      (interrupt),
		.irq            (irq),
		.head           (head),
		.empty          (empty),
		.pop            (pop),
		.retire         (retire),
		.int_enabled    (int_enabled)
	);

endmodule

// ==== design/cpu_pipeline.sv ====
// Five-stage CPU pipeline
`include "frontend_defines.svh"

module cpu_pipeline (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       stall,
	input  logic                       load_pc,
	input  logic                       int_enable_set,
	input  logic                       interrupt,
	input  logic [3:0]                 irq,
	input  frontend_pkg::fetch_word_t  head,
	input  logic                       empty,
	output logic                       pop,
	output frontend_pkg::retire_t      retire,
	output logic                       int_enabled
);

	import frontend_pkg::*;

	stage_t                stg [5];       // 0 fetch latch, 1 decode, 2 execute, 3 memory, 4 write-back
	logic [`WORD_BITS-1:0] opnd [2:4];    // Combined operand beside stages 2 to 4
	logic [11:0]           imm_q;         // Immediate from the last prefix
	logic                  imm_held;      // Prefix waiting for its successor
	logic                  int_flag;
	logic                  advance;
	logic                  inject;
	stage_t                s0_next;
	stage_t                s2_next;
	logic [`WORD_BITS-1:0] opnd_next;

	// Front stages move only without stall or flush
	assign advance = !stall && !load_pc;

	// INT takes the slot of head, which stays queued
	assign inject = int_flag && interrupt && advance && !empty;
	assign pop    = advance && !empty && !inject;

	assign int_enabled    = int_flag;
	assign retire.stage   = stg[4];
	assign retire.operand = opnd[4];

	// What enters the fetch latch
	always_comb begin
		s0_next.valid = 1'b0;
		s0_next.instr = `NOP_WORD;
		s0_next.addr  = head.addr;   // Return address for an injected INT
		if (inject) begin
			s0_next.valid = 1'b1;
			s0_next.instr = {`INT_BASE, irq};
		end else if (!empty) begin
			s0_next.valid = 1'b1;
			s0_next.instr = head.instr;
		end
	end

	// Decode to execute, operand combining
	always_comb begin
		s2_next   = stg[1];
		opnd_next = {12'h000, stg[1].instr.rf.lo};
		if (is_prefix(stg[1]))
			s2_next.valid = 1'b0;     // Prefix retires as a bubble
		else if (imm_held)
			opnd_next = {imm_q, stg[1].instr.rf.lo};
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 5; i++)
				stg[i].valid <= 1'b0;
			imm_held <= 1'b0;
		end else begin
			// Memory and write-back always drain
			stg[4] <= stg[3];
			stg[3] <= stg[2];

			if (load_pc) begin
				// Branch taken, squash fetch latch through execute
				for (int i = 0; i < 3; i++) begin
					stg[i].valid <= 1'b0;
					stg[i].instr <= `NOP_WORD;
				end
				imm_held <= 1'b0;
			end else if (stall) begin
				stg[2].valid <= 1'b0;     // Bubble into execute
				stg[2].instr <= `NOP_WORD;
			end else begin
				stg[2] <= s2_next;
				stg[1] <= stg[0];
				stg[0] <= s0_next;
				if (is_prefix(stg[1]))
					imm_held <= 1'b1;
				else if (stg[1].valid)
					imm_held <= 1'b0;  // Consumed, bubbles leave it alone
			end
		end
	end

	// Operand and immediate payload
	always_ff @(posedge CLK) begin
		if (advance) begin
			opnd[2] <= opnd_next;
			if (is_prefix(stg[1]))
				imm_q <= stg[1].instr.imm.imm;
		end
		opnd[3] <= opnd[2];
		opnd[4] <= opnd[3];
	end

	// Interrupt enable, cleared by the injection it allows
	always_ff @(posedge CLK) begin
		if (!RSTb)
			int_flag <= 1'b0;
		else if (inject)
			int_flag <= 1'b0;
		else if (int_enable_set)
			int_flag <= 1'b1;
	end

endmodule

// ==== design/fetch_unit.sv ====
// Credit-based instruction fetch
`include "frontend_defines.svh"

module fetch_unit (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       load_pc,
	input  logic [`ADDR_BITS-1:0]      target_pc,
	input  logic                       credit_return,
	output logic                       mem_req,
	output logic [`ADDR_BITS-1:0]      mem_addr,
	input  logic [`WORD_BITS-1:0]      mem_data,
	output logic                       push,
	output frontend_pkg::fetch_word_t  push_word
);

	localparam int CRED_BITS = $clog2(`BUF_DEPTH + 1);

	logic [`ADDR_BITS-1:0] pc;           // Next sequential address to request
	logic [CRED_BITS-1:0]  credits;      // Free buffer slots not yet claimed
	logic                  issue;
	logic                  in_flight;    // Memory word due on mem_data this cycle
	logic [`ADDR_BITS-1:0] flight_addr;

	// Each request claims one buffer slot in advance
	assign issue = (credits != '0);

	// Stale word is dropped in a load cycle
	assign push = in_flight && !load_pc;
	assign push_word.instr = mem_data;
	assign push_word.addr  = flight_addr;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			mem_req   <= 1'b0;
			pc        <= '0;
			credits   <= CRED_BITS'(`BUF_DEPTH);
			in_flight <= 1'b0;
		end else if (load_pc) begin
			// Restart at target, pool refilled minus this request
			mem_req   <= 1'b1;
			pc        <= target_pc + 1'b1;
			credits   <= CRED_BITS'(`BUF_DEPTH - 1);
			in_flight <= 1'b0;   // Word requested now belongs to the old stream
		end else begin
			mem_req   <= issue;
			in_flight <= mem_req;
			if (issue)
				pc <= pc + 1'b1;
			credits <= credits - CRED_BITS'(issue) + CRED_BITS'(credit_return);
		end
	end

	// Request address and the address of the word in flight
	always_ff @(posedge CLK) begin
		if (load_pc)
			mem_addr <= target_pc;
		else if (issue)
			mem_addr <= pc;

		if (mem_req)
			flight_addr <= mem_addr;
	end

endmodule

// ==== design/frontend_defines.svh ====
// Front end constants
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// Datapath widths
`define WORD_BITS 16
`define ADDR_BITS 16

// Queue entries, also the fetch credit pool
`define BUF_DEPTH 8

// Fixed encodings
`define NOP_WORD 16'h0000
`define OP_IMM   4'h1
`define INT_BASE 12'h050 // Upper part of the injected INT word

`endif

// ==== design/frontend_pkg.sv ====
// Front end shared types
`include "frontend_defines.svh"

package frontend_pkg;

	// Immediate prefix, carries the upper 12 bits of an operand
	typedef struct packed {
		logic [3:0]  opcode;
		logic [11:0] imm;
	} imm_view_t;

	// Ordinary register format
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] rd;
		logic [3:0] ra;
		logic [3:0] lo;     // Low operand nibble
	} reg_view_t;

	// One instruction word, two decodes
	typedef union packed {
		imm_view_t imm;
		reg_view_t rf;
	} instr_u;

	// Fetched word with its address
	typedef struct packed {
		instr_u                instr;
		logic [`ADDR_BITS-1:0] addr;
	} fetch_word_t;

	// One pipeline slot
	typedef struct packed {
		logic                  valid;
		instr_u                instr;
		logic [`ADDR_BITS-1:0] addr;
	} stage_t;

	// Write-back port contents
	typedef struct packed {
		stage_t                stage;
		logic [`WORD_BITS-1:0] operand;  // Prefix immediate joined with low field
	} retire_t;

	// Valid slot holding an immediate prefix
	function automatic logic is_prefix(stage_t s);
		return s.valid && (s.instr.imm.opcode == `OP_IMM);
	endfunction

endpackage

// ==== design/instr_buffer.sv ====
// Instruction and address queue
`include "frontend_defines.svh"

module instr_buffer (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic                       load_pc,
	input  logic                       push,
	input  frontend_pkg::fetch_word_t  push_word,
	input  logic                       pop,
	output frontend_pkg::fetch_word_t  head,
	output logic                       empty,
	output logic                       credit_return
);

	import frontend_pkg::*;

	localparam int PTR_BITS = $clog2(`BUF_DEPTH);

	fetch_word_t          entries [`BUF_DEPTH];
	logic [PTR_BITS:0]    wr_ptr;     // Top bit tells full from empty
	logic [PTR_BITS:0]    rd_ptr;
	logic                 do_push;
	logic                 do_pop;

	// Flush wins over both ends of the queue
	assign do_push = push && !load_pc;
	assign do_pop  = pop && !empty && !load_pc;

	assign empty = (wr_ptr == rd_ptr);
	assign head  = entries[rd_ptr[PTR_BITS-1:0]];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= do_pop;      // One credit back per word taken
			if (load_pc) begin
				// Dropped entries are covered by the fetch unit's refill
				wr_ptr <= '0;
				rd_ptr <= '0;
			end else begin
				if (do_push)
					wr_ptr <= wr_ptr + 1'b1;
				if (do_pop)
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge CLK) begin
		if (do_push)
			entries[wr_ptr[PTR_BITS-1:0]] <= push_word;
	end

endmodule

// ==== src.f ====
+incdir+design
design/frontend_pkg.sv
design/fetch_unit.sv
design/instr_buffer.sv
design/cpu_pipeline.sv
design/cpu_frontend.sv
tests/cpu_frontend_sva.sv
tests/tb_cpu_frontend.sv

// ==== tests/cpu_frontend_sva.sv ====
// Front end control assertions
`include "frontend_defines.svh"

module cpu_frontend_sva (
	input logic                              CLK,
	input logic                              RSTb,
	input logic [$clog2(`BUF_DEPTH + 1)-1:0] credits,
	input logic                              pop,
	input logic                              empty,
	input logic                              stall,
	input logic                              retire_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	int fails = 0;   // Failed assertions so far

	// A request made with no credit left wraps the count past the depth
	a_credit_range: assert property (@(posedge CLK) disable iff (!RSTb)
		credits <= `BUF_DEPTH)
		else begin
			$error("credit count above buffer depth, request made without credit");
			fails++;
		end

	a_pop_ready: assert property (@(posedge CLK) disable iff (!RSTb)
		pop |-> (!empty && !stall))
		else begin
			$error("pop while buffer empty or pipeline stalled");
			fails++;
		end

	a_reset_retire: assert property (@(posedge CLK)
		$rose(RSTb) |-> !retire_valid)
		else begin
			$error("retire valid right after reset");
			fails++;
		end

endmodule

bind fetch_unit cpu_frontend_sva sva_fetch (
	.CLK(CLK), .RSTb(RSTb), .credits(credits),
	.pop(1'b0), .empty(1'b0), .stall(1'b0), .retire_valid(1'b0)
);

bind cpu_pipeline cpu_frontend_sva sva_pipe (
	.CLK(CLK), .RSTb(RSTb), .credits('0),
	.pop(pop), .empty(empty), .stall(stall), .retire_valid(retire.stage.valid)
);

// ==== tests/tb_cpu_frontend.sv ====
// CPU front end testbench
`include "frontend_defines.svh"

module tb_cpu_frontend;
	timeunit 1ns;
	timeprecision 1ps;

	import frontend_pkg::*;

	localparam int PERIOD       = 40;
	localparam int RESET_CYC    = 16;
	localparam int CYC_STRAIGHT = 300;
	localparam int CYC_IMM      = 300;
	localparam int CYC_STALL    = 600;
	localparam int CYC_FLUSH    = 600;
	localparam int INT_ROUNDS   = 8;
	localparam int INT_WAIT     = 40;   // Cycles allowed for one injection
	localparam int INT_DRAIN    = 30;
	localparam int TOTAL_CYC    = RESET_CYC + CYC_STRAIGHT + CYC_IMM + CYC_STALL + CYC_FLUSH
		+ INT_ROUNDS * (3 + INT_WAIT + INT_DRAIN);

	logic                  CLK, RSTb, stall, load_pc, int_enable_set, interrupt;
	logic [3:0]            irq;
	logic [`ADDR_BITS-1:0] target_pc, mem_addr, pend_addr;
	logic [`WORD_BITS-1:0] mem_data;
	logic                  mem_req, int_enabled;
	logic                  pend_req;    // Request seen in the last cycle
	retire_t               retire;

	// Reference model state
	logic [`ADDR_BITS-1:0] exp_addr, flush_target;  // Next program address due to retire
	logic                  held, int_expect;
	logic [11:0]           held_imm;
	logic [3:0]            int_irq;
	integer                seed;
	int                    errors, checks, retired, combined, int_seen;
	int                    flush_wait, flush_count, stall_left, tests_run;

	cpu_frontend dut0 (
		.CLK(CLK), .RSTb(RSTb), .stall(stall), .load_pc(load_pc), .target_pc(target_pc),
		.int_enable_set(int_enable_set), .interrupt(interrupt), .irq(irq),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_data(mem_data),
		.retire(retire), .int_enabled(int_enabled)
	);

	// Program image, roughly one word in four is an immediate prefix
	function automatic logic [`WORD_BITS-1:0] mem_word(input logic [`ADDR_BITS-1:0] a);
		logic [15:0] h;
		logic [3:0]  op;
		h  = (a * 16'hA5B3) ^ {a[6:0], a[15:7]} ^ 16'h3C5A;
		op = (h[13:12] == 2'b00) ? `OP_IMM : {1'b1, h[14:12]};  // Opcode 0 kept for INT
		return {op, h[11:0]};
	endfunction

	function automatic logic is_prefix_word(input logic [`WORD_BITS-1:0] w);
		return w[15:12] == `OP_IMM;
	endfunction

	task automatic compare(input string name, input logic [15:0] expv, input logic [15:0] got);
		checks++;
		if (got !== expv) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, expv, got);
		end
	endtask

	task automatic take_prefix();
		logic [`WORD_BITS-1:0] pw;
		pw = mem_word(exp_addr);
		held     = 1'b1;
		held_imm = pw[11:0];
		exp_addr = exp_addr + 1'b1;
	endtask

	task automatic check_retire();
		logic [`WORD_BITS-1:0] w, expw, exp_opnd;
		int                    guard;
		if (!retire.stage.valid)
			return;
		w = retire.stage.instr;
		guard = 0;
		retired++;
		if (int_expect && w == {`INT_BASE, int_irq}) begin
			// Prefixes ahead of the INT slot were already in the pipe
			while (exp_addr != retire.stage.addr && is_prefix_word(mem_word(exp_addr))
					&& guard < 8) begin
				take_prefix();
				guard++;
			end
			exp_opnd = held ? {held_imm, int_irq} : {12'h000, int_irq};
			compare("retire.stage.addr", exp_addr, retire.stage.addr);
			compare("retire.operand", exp_opnd, retire.operand);
			int_expect = 1'b0;
			int_seen++;
		end else begin
			while (is_prefix_word(mem_word(exp_addr)) && guard < 8) begin
				take_prefix();
				guard++;
			end
			expw     = mem_word(exp_addr);
			exp_opnd = held ? {held_imm, expw[3:0]} : {12'h000, expw[3:0]};
			compare("retire.stage.addr", exp_addr, retire.stage.addr);
			compare("retire.stage.instr", expw, w);
			compare("retire.operand", exp_opnd, retire.operand);
			if (held)
				combined++;
			exp_addr = exp_addr + 1'b1;
		end
		held = 1'b0;
	endtask

	// One cycle, outputs sampled at the falling edge before new inputs go out
	task automatic tick();
		@(negedge CLK);
		check_retire();
		if (flush_wait > 0) begin
			flush_wait--;
			if (flush_wait == 0) begin  // Old stream has drained from memory and write-back
				exp_addr = flush_target;
				held     = 1'b0;
			end
		end
	endtask

	task automatic run_phase(input int cycles, input bit use_stall, input bit use_flush);
		int i;
		stall_left = 0;
		for (i = 0; i < cycles; i++) begin
			tick();
			load_pc = 1'b0;
			if (use_stall) begin
				if (stall_left > 0)
					stall_left--;
				else if ({$random(seed)} % 10 == 0)
					stall_left = 1 + {$random(seed)} % 12;
			end
			stall = (stall_left > 0);
			if (use_flush && flush_wait == 0 && i < cycles - 20 && {$random(seed)} % 25 == 0) begin
				load_pc      = 1'b1;
				target_pc    = $random(seed);
				flush_target = target_pc;
				flush_wait   = 2;
				flush_count++;
			end
		end
		stall   = 1'b0;
		load_pc = 1'b0;
	endtask

	task automatic report_test(input int num, input string name, input int err0, input int ret0);
		if (retired == ret0) begin
			errors++;
			$display("test %0d: no instruction retired", num);
		end
		tests_run++;
		$display("test %0d %s: %0d retired, %0d errors", num, name, retired - ret0,
			errors - err0);
	endtask

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// Synchronous memory, word valid one cycle after a request
	always @(negedge CLK) begin
		mem_data  = pend_req ? mem_word(pend_addr) : `NOP_WORD;  // Nothing without a request
		pend_req  = mem_req;
		pend_addr = mem_addr;
	end

	initial begin
		#(PERIOD * (TOTAL_CYC + 500));
		$display("Watchdog expired at %0t, the run did not finish", $time);
		$display("Test failed");
		$finish;
	end

	initial begin
		int err0, ret0, comb0, seen0, n, k, asserts;
		seed = 77564;
		{RSTb, stall, load_pc, int_enable_set, interrupt} = '0;
		irq = '0;
		target_pc = '0;
		mem_data = '0;
		pend_addr = '0;
		pend_req = 1'b0;
		exp_addr = '0;
		{held, int_expect} = '0;
		{errors, checks, retired, combined, int_seen, flush_wait, flush_count, tests_run} = '0;
		repeat (RESET_CYC) @(negedge CLK);
		RSTb = 1'b1;

		err0 = errors;
		ret0 = retired;
		run_phase(CYC_STRAIGHT, 1'b0, 1'b0);
		report_test(1, "straight-line order", err0, ret0);

		err0 = errors;
		ret0 = retired;
		comb0 = combined;
		run_phase(CYC_IMM, 1'b0, 1'b0);
		if (combined == comb0) begin
			errors++;
			$display("test 2: no instruction with a prefix retired");
		end
		report_test(2, "immediate combining", err0, ret0);

		err0 = errors;
		ret0 = retired;
		run_phase(CYC_STALL, 1'b1, 1'b0);
		report_test(3, "stall safety", err0, ret0);

		err0 = errors;
		ret0 = retired;
		run_phase(CYC_FLUSH, 1'b1, 1'b1);
		if (flush_count == 0) begin
			errors++;
			$display("test 4: no branch load was issued");
		end
		report_test(4, "flush", err0, ret0);

		err0 = errors;
		ret0 = retired;
		for (k = 0; k < INT_ROUNDS; k++) begin
			tick();
			int_enable_set = 1'b1;
			tick();
			int_enable_set = 1'b0;
			interrupt  = 1'b1;
			irq        = $random(seed);
			int_irq    = irq;
			int_expect = 1'b1;
			seen0      = int_seen;
			n = 0;
			tick();
			while (int_enabled && n < INT_WAIT) begin
				tick();
				n++;
			end
			interrupt = 1'b0;
			repeat (INT_DRAIN) tick();
			if (int_enabled) begin
				errors++;
				$display("test 5: round %0d interrupt was never taken", k);
			end
			if (int_seen - seen0 != 1) begin
				errors++;
				$display("test 5: round %0d retired %0d interrupt words", k, int_seen - seen0);
			end
		end
		report_test(5, "interrupt", err0, ret0);

		asserts = dut0.u_fetch.sva_fetch.fails + dut0.u_pipe.sva_pipe.fails;
		if (asserts != 0) begin
			errors += asserts;
			$display("%0d assertion failures in the bound checkers", asserts);
		end

		$display("tests %0d, checks %0d, retired %0d, errors %0d", tests_run, checks, retired,
			errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
